//--- common/ucb_pkg.sv
`default_nettype none

package ucb_pkg;

	// Works for anything from 2 to 8 ports
	localparam int NUM_PORTS = 4;

	// AXI ID must be wide enough to carry a port index
	localparam int ID_WIDTH  = 4;
	localparam int IDX_WIDTH = $clog2(NUM_PORTS);

	typedef logic [31:0]          addr_t;
	typedef logic [31:0]          word_t;
	typedef logic [ID_WIDTH-1:0]  axi_id_t;
	typedef logic [IDX_WIDTH-1:0] port_idx_t;

	// Single-beat word transfers only
	localparam logic [1:0] BURST_INCR = 2'b01;
	localparam logic [7:0] LEN_SINGLE = 8'd0;
	localparam logic [2:0] SIZE_WORD  = 3'd2;
	localparam logic [3:0] STRB_ALL   = 4'b1111;

	typedef enum logic [2:0] {
		idle,
		read_addr,
		read_data,
		write_addr,
		write_data,
		write_resp,
		finished
	} pass_state_t;

endpackage

`default_nettype wire

//--- design/dbus_pass.sv
`default_nettype none

module dbus_pass (
	input  logic           clk,
	input  logic           rst,
	// CPU data bus
	input  logic           read,
	input  logic           write,
	input  ucb_pkg::addr_t address,
	input  ucb_pkg::word_t wrdata,
	output logic           stall,
	output ucb_pkg::word_t rddata,
	// AR
	output logic           eng_arvalid,
	output ucb_pkg::addr_t eng_araddr,
	input  logic           eng_arready,
	// AW
	output logic           eng_awvalid,
	output ucb_pkg::addr_t eng_awaddr,
	input  logic           eng_awready,
	// W
	output logic           eng_wvalid,
	output ucb_pkg::word_t eng_wdata,
	input  logic           eng_wready,
	// Responses arrive here already routed by ID
	input  logic           eng_rvalid,
	input  ucb_pkg::word_t eng_rdata,
	input  logic           eng_bvalid
);

	ucb_pkg::pass_state_t state, state_d;

	logic           pipe_read;
	logic           pipe_write;
	ucb_pkg::addr_t pipe_addr;
	ucb_pkg::word_t pipe_wdata;

	// Port stays stalled until the FSM heads back to idle
	assign stall = (state_d != ucb_pkg::idle);

	// Payload comes straight from the captured request
	assign eng_arvalid = (state == ucb_pkg::read_addr);
	assign eng_araddr  = pipe_addr;
	assign eng_awvalid = (state == ucb_pkg::write_addr);
	assign eng_awaddr  = pipe_addr;
	assign eng_wvalid  = (state == ucb_pkg::write_data);
	assign eng_wdata   = pipe_wdata;

	always_comb begin
		state_d = state;
		case (state)
			ucb_pkg::idle: begin
				// Load wins if the CPU raises both
				if (pipe_read) begin
					state_d = ucb_pkg::read_addr;
				end else if (pipe_write) begin
					state_d = ucb_pkg::write_addr;
				end
			end
			ucb_pkg::read_addr: begin
				if (eng_arready) state_d = ucb_pkg::read_data;
			end
			ucb_pkg::read_data: begin
				if (eng_rvalid) state_d = ucb_pkg::finished;
			end
			ucb_pkg::write_addr: begin
				if (eng_awready) state_d = ucb_pkg::write_data;
			end
			ucb_pkg::write_data: begin
				if (eng_wready) state_d = ucb_pkg::write_resp;
			end
			ucb_pkg::write_resp: begin
				// Store is done only once B comes back
				if (eng_bvalid) state_d = ucb_pkg::finished;
			end
			ucb_pkg::finished: begin
				state_d = ucb_pkg::idle;
			end
			default: begin
				state_d = ucb_pkg::idle;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ucb_pkg::idle;
		end else begin
			state <= state_d;
		end
	end

	// Request flags follow the CPU whenever the port is free
	always_ff @(posedge clk) begin
		if (rst) begin
			pipe_read  <= 1'b0;
			pipe_write <= 1'b0;
		end else if (!stall) begin
			pipe_read  <= read;
			pipe_write <= write;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			pipe_addr  <= address;
			pipe_wdata <= wrdata;
		end
	end

	// Loaded word, or the stored word once the store completes
	always_ff @(posedge clk) begin
		if (rst) begin
			rddata <= '0;
		end else if (state == ucb_pkg::read_data && eng_rvalid) begin
			rddata <= eng_rdata;
		end else if (state == ucb_pkg::write_resp && eng_bvalid) begin
			rddata <= pipe_wdata;
		end
	end

	ar_aw_exclusive: assert property (@(posedge clk) disable iff (rst)
		!(eng_arvalid && eng_awvalid));

	ar_held: assert property (@(posedge clk) disable iff (rst)
		eng_arvalid && !eng_arready |=> eng_arvalid && $stable(eng_araddr));

	aw_held: assert property (@(posedge clk) disable iff (rst)
		eng_awvalid && !eng_awready |=> eng_awvalid && $stable(eng_awaddr));

	w_held: assert property (@(posedge clk) disable iff (rst)
		eng_wvalid && !eng_wready |=> eng_wvalid && $stable(eng_wdata));

endmodule

`default_nettype wire

//--- design/axi_id_arbiter.sv
`default_nettype none

module axi_id_arbiter (
	input  logic                                         clk,
	input  logic                                         rst,
	// Engine side
	input  logic [ucb_pkg::NUM_PORTS-1:0]                eng_arvalid,
	input  ucb_pkg::addr_t [ucb_pkg::NUM_PORTS-1:0]      eng_araddr,
	output logic [ucb_pkg::NUM_PORTS-1:0]                eng_arready,
	input  logic [ucb_pkg::NUM_PORTS-1:0]                eng_awvalid,
	input  ucb_pkg::addr_t [ucb_pkg::NUM_PORTS-1:0]      eng_awaddr,
	output logic [ucb_pkg::NUM_PORTS-1:0]                eng_awready,
	input  logic [ucb_pkg::NUM_PORTS-1:0]                eng_wvalid,
	input  ucb_pkg::word_t [ucb_pkg::NUM_PORTS-1:0]      eng_wdata,
	output logic [ucb_pkg::NUM_PORTS-1:0]                eng_wready,
	output logic [ucb_pkg::NUM_PORTS-1:0]                eng_rvalid,
	output ucb_pkg::word_t [ucb_pkg::NUM_PORTS-1:0]      eng_rdata,
	output logic [ucb_pkg::NUM_PORTS-1:0]                eng_bvalid,
	// AXI4 master
	output ucb_pkg::axi_id_t                             arid,
	output ucb_pkg::addr_t                               araddr,
	output logic [7:0]                                   arlen,
	output logic [2:0]                                   arsize,
	output logic [1:0]                                   arburst,
	output logic                                         arvalid,
	input  logic                                         arready,
	output ucb_pkg::axi_id_t                             awid,
	output ucb_pkg::addr_t                               awaddr,
	output logic [7:0]                                   awlen,
	output logic [2:0]                                   awsize,
	output logic [1:0]                                   awburst,
	output logic                                         awvalid,
	input  logic                                         awready,
	output ucb_pkg::word_t                               wdata,
	output logic [3:0]                                   wstrb,
	output logic                                         wlast,
	output logic                                         wvalid,
	input  logic                                         wready,
	input  ucb_pkg::axi_id_t                             rid,
	input  ucb_pkg::word_t                               rdata,
	input  logic [1:0]                                   rresp,
	input  logic                                         rlast,
	input  logic                                         rvalid,
	output logic                                         rready,
	input  ucb_pkg::axi_id_t                             bid,
	input  logic [1:0]                                   bresp,
	input  logic                                         bvalid,
	output logic                                         bready
);

	ucb_pkg::port_idx_t ar_ptr, ar_hold_idx, ar_idx;
	ucb_pkg::port_idx_t aw_ptr, aw_hold_idx, aw_idx;
	ucb_pkg::port_idx_t w_idx;
	logic               ar_hold, aw_hold;
	logic               w_locked;

	function automatic ucb_pkg::port_idx_t rr_next(input ucb_pkg::port_idx_t idx);
		return (idx == ucb_pkg::port_idx_t'(ucb_pkg::NUM_PORTS - 1)) ? '0 : idx + 1'b1;
	endfunction

	// First requester at or after ptr, or ptr itself when none
	function automatic ucb_pkg::port_idx_t rr_pick(
		input logic [ucb_pkg::NUM_PORTS-1:0] req,
		input ucb_pkg::port_idx_t            ptr
	);
		ucb_pkg::port_idx_t cur;
		ucb_pkg::port_idx_t pick;
		logic               found;
		cur   = ptr;
		pick  = ptr;
		found = 1'b0;
		for (int i = 0; i < ucb_pkg::NUM_PORTS; i++) begin
			if (!found && req[cur]) begin
				pick  = cur;
				found = 1'b1;
			end
			cur = rr_next(cur);
		end
		return pick;
	endfunction

	// A stalled grant is held so the payload cannot switch mid-request
	assign ar_idx = ar_hold ? ar_hold_idx : rr_pick(eng_arvalid, ar_ptr);
	assign aw_idx = aw_hold ? aw_hold_idx : rr_pick(eng_awvalid, aw_ptr);

	assign arvalid = eng_arvalid[ar_idx];
	assign araddr  = eng_araddr[ar_idx];
	assign arid    = ucb_pkg::axi_id_t'(ar_idx);
	assign arlen   = ucb_pkg::LEN_SINGLE;
	assign arsize  = ucb_pkg::SIZE_WORD;
	assign arburst = ucb_pkg::BURST_INCR;

	// No new AW until the locked W beat has gone out
	assign awvalid = !w_locked && eng_awvalid[aw_idx];
	assign awaddr  = eng_awaddr[aw_idx];
	assign awid    = ucb_pkg::axi_id_t'(aw_idx);
	assign awlen   = ucb_pkg::LEN_SINGLE;
	assign awsize  = ucb_pkg::SIZE_WORD;
	assign awburst = ucb_pkg::BURST_INCR;

	assign wvalid = w_locked && eng_wvalid[w_idx];
	assign wdata  = eng_wdata[w_idx];
	assign wstrb  = ucb_pkg::STRB_ALL;
	assign wlast  = 1'b1;

	// Every engine that can get a response is already waiting for it
	assign rready = 1'b1;
	assign bready = 1'b1;

	genvar g;
	generate
		for (g = 0; g < ucb_pkg::NUM_PORTS; g++) begin : g_route
			assign eng_arready[g] = arvalid && arready && (ar_idx == g);
			assign eng_awready[g] = awvalid && awready && (aw_idx == g);
			assign eng_wready[g]  = w_locked && wready && (w_idx == g);
			assign eng_rvalid[g]  = rvalid && (rid == ucb_pkg::axi_id_t'(g));
			assign eng_bvalid[g]  = bvalid && (bid == ucb_pkg::axi_id_t'(g));
			assign eng_rdata[g]   = rdata;
		end
	endgenerate

	always_ff @(posedge clk) begin
		if (rst) begin
			ar_ptr      <= '0;
			ar_hold     <= 1'b0;
			ar_hold_idx <= '0;
		end else if (arvalid && arready) begin
			ar_ptr  <= rr_next(ar_idx);
			ar_hold <= 1'b0;
		end else if (arvalid) begin
			ar_hold     <= 1'b1;
			ar_hold_idx <= ar_idx;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			aw_ptr      <= '0;
			aw_hold     <= 1'b0;
			aw_hold_idx <= '0;
		end else if (awvalid && awready) begin
			aw_ptr  <= rr_next(aw_idx);
			aw_hold <= 1'b0;
		end else if (awvalid) begin
			aw_hold     <= 1'b1;
			aw_hold_idx <= aw_idx;
		end
	end

	// Write lock spans AW handshake to W handshake
	always_ff @(posedge clk) begin
		if (rst) begin
			w_locked <= 1'b0;
			w_idx    <= '0;
		end else if (awvalid && awready) begin
			w_locked <= 1'b1;
			w_idx    <= aw_idx;
		end else if (wvalid && wready) begin
			w_locked <= 1'b0;
		end
	end

	one_grant: assert property (@(posedge clk) disable iff (rst)
		$onehot0(eng_arready) && $onehot0(eng_awready));

	// Only the engine behind the granted AW may be presenting W
	w_needs_lock: assert property (@(posedge clk) disable iff (rst)
		eng_wvalid != '0 |-> w_locked && $onehot(eng_wvalid) && eng_wvalid[w_idx]);

	ar_grant_kept: assert property (@(posedge clk) disable iff (rst)
		arvalid && !arready |=> arvalid && $stable(arid) && $stable(araddr));

	r_single_beat: assert property (@(posedge clk) disable iff (rst)
		rvalid |-> rlast && (rid < ucb_pkg::axi_id_t'(ucb_pkg::NUM_PORTS)));

endmodule

`default_nettype wire

//--- design/uncached_bridge_top.sv
`default_nettype none

module uncached_bridge_top (
	input  logic                                    clk,
	input  logic                                    rst,
	// One CPU data bus per port
	input  logic [ucb_pkg::NUM_PORTS-1:0]           cpu_read,
	input  logic [ucb_pkg::NUM_PORTS-1:0]           cpu_write,
	input  ucb_pkg::addr_t [ucb_pkg::NUM_PORTS-1:0] cpu_address,
	input  ucb_pkg::word_t [ucb_pkg::NUM_PORTS-1:0] cpu_wrdata,
	output logic [ucb_pkg::NUM_PORTS-1:0]           cpu_stall,
	output ucb_pkg::word_t [ucb_pkg::NUM_PORTS-1:0] cpu_rddata,
	// AXI4 master
	output ucb_pkg::axi_id_t                        arid,
	output ucb_pkg::addr_t                          araddr,
	output logic [7:0]                              arlen,
	output logic [2:0]                              arsize,
	output logic [1:0]                              arburst,
	output logic                                    arvalid,
	input  logic                                    arready,
	output ucb_pkg::axi_id_t                        awid,
	output ucb_pkg::addr_t                          awaddr,
	output logic [7:0]                              awlen,
	output logic [2:0]                              awsize,
	output logic [1:0]                              awburst,
	output logic                                    awvalid,
	input  logic                                    awready,
	output ucb_pkg::word_t                          wdata,
	output logic [3:0]                              wstrb,
	output logic                                    wlast,
	output logic                                    wvalid,
	input  logic                                    wready,
	input  ucb_pkg::axi_id_t                        rid,
	input  ucb_pkg::word_t                          rdata,
	input  logic [1:0]                              rresp,
	input  logic                                    rlast,
	input  logic                                    rvalid,
	output logic                                    rready,
	input  ucb_pkg::axi_id_t                        bid,
	input  logic [1:0]                              bresp,
	input  logic                                    bvalid,
	output logic                                    bready
);

	logic [ucb_pkg::NUM_PORTS-1:0]           eng_arvalid, eng_arready;
	logic [ucb_pkg::NUM_PORTS-1:0]           eng_awvalid, eng_awready;
	logic [ucb_pkg::NUM_PORTS-1:0]           eng_wvalid, eng_wready;
	logic [ucb_pkg::NUM_PORTS-1:0]           eng_rvalid, eng_bvalid;
	ucb_pkg::addr_t [ucb_pkg::NUM_PORTS-1:0] eng_araddr, eng_awaddr;
	ucb_pkg::word_t [ucb_pkg::NUM_PORTS-1:0] eng_wdata, eng_rdata;

	// One engine per CPU port; its index doubles as its AXI ID
	genvar g;
	generate
		for (g = 0; g < ucb_pkg::NUM_PORTS; g++) begin : g_pass
			dbus_pass u_pass (
				.clk         (clk),
				.rst         (rst),
				.read        (cpu_read[g]),
				.write       (cpu_write[g]),
				.address     (cpu_address[g]),
				.wrdata      (cpu_wrdata[g]),
				.stall       (cpu_stall[g]),
				.rddata      (cpu_rddata[g]),
				.eng_arvalid (eng_arvalid[g]),
				.eng_araddr  (eng_araddr[g]),
				.eng_arready (eng_arready[g]),
				.eng_awvalid (eng_awvalid[g]),
				.eng_awaddr  (eng_awaddr[g]),
				.eng_awready (eng_awready[g]),
				.eng_wvalid  (eng_wvalid[g]),
				.eng_wdata   (eng_wdata[g]),
				.eng_wready  (eng_wready[g]),
				.eng_rvalid  (eng_rvalid[g]),
				.eng_rdata   (eng_rdata[g]),
				.eng_bvalid  (eng_bvalid[g])
			);
		end
	endgenerate

	axi_id_arbiter u_arbiter (
		.clk         (clk),
		.rst         (rst),
		.eng_arvalid (eng_arvalid),
		.eng_araddr  (eng_araddr),
		.eng_arready (eng_arready),
		.eng_awvalid (eng_awvalid),
		.eng_awaddr  (eng_awaddr),
		.eng_awready (eng_awready),
		.eng_wvalid  (eng_wvalid),
		.eng_wdata   (eng_wdata),
		.eng_wready  (eng_wready),
		.eng_rvalid  (eng_rvalid),
		.eng_rdata   (eng_rdata),
		.eng_bvalid  (eng_bvalid),
		.arid        (arid),
		.araddr      (araddr),
		.arlen       (arlen),
		.arsize      (arsize),
		.arburst     (arburst),
		.arvalid     (arvalid),
		.arready     (arready),
		.awid        (awid),
		.awaddr      (awaddr),
		.awlen       (awlen),
		.awsize      (awsize),
		.awburst     (awburst),
		.awvalid     (awvalid),
		.awready     (awready),
		.wdata       (wdata),
		.wstrb       (wstrb),
		.wlast       (wlast),
		.wvalid      (wvalid),
		.wready      (wready),
		.rid         (rid),
		.rdata       (rdata),
		.rresp       (rresp),
		.rlast       (rlast),
		.rvalid      (rvalid),
		.rready      (rready),
		.bid         (bid),
		.bresp       (bresp),
		.bvalid      (bvalid),
		.bready      (bready)
	);

endmodule

`default_nettype wire

//--- tests/ucb_checker.sv
`default_nettype none

module ucb_checker (
	input  logic                                    clk,
	input  logic                                    rst,
	input  logic [2:0]                              phase,
	input  logic [ucb_pkg::NUM_PORTS-1:0]           cpu_read,
	input  logic [ucb_pkg::NUM_PORTS-1:0]           cpu_write,
	input  ucb_pkg::addr_t [ucb_pkg::NUM_PORTS-1:0] cpu_address,
	input  ucb_pkg::word_t [ucb_pkg::NUM_PORTS-1:0] cpu_wrdata,
	input  logic [ucb_pkg::NUM_PORTS-1:0]           cpu_stall,
	input  ucb_pkg::word_t [ucb_pkg::NUM_PORTS-1:0] cpu_rddata,
	input  ucb_pkg::axi_id_t                        arid,
	input  ucb_pkg::addr_t                          araddr,
	input  logic [7:0]                              arlen,
	input  logic [2:0]                              arsize,
	input  logic [1:0]                              arburst,
	input  logic                                    arvalid,
	input  logic                                    arready,
	input  ucb_pkg::axi_id_t                        awid,
	input  ucb_pkg::addr_t                          awaddr,
	input  logic [7:0]                              awlen,
	input  logic [2:0]                              awsize,
	input  logic [1:0]                              awburst,
	input  logic                                    awvalid,
	input  logic                                    awready,
	input  ucb_pkg::word_t                          wdata,
	input  logic [3:0]                              wstrb,
	input  logic                                    wlast,
	input  logic                                    wvalid,
	input  logic                                    wready,
	input  logic                                    rready,
	input  logic                                    bready,
	output int                                      error_count,
	output int                                      check_count
);

	timeunit 1ns;
	timeprecision 1ps;

	ucb_pkg::word_t                ref_mem [ucb_pkg::addr_t];
	ucb_pkg::word_t                pend_exp [ucb_pkg::NUM_PORTS];
	logic [ucb_pkg::NUM_PORTS-1:0] pending;
	logic [ucb_pkg::NUM_PORTS-1:0] stall_q;
	logic                          ar_wait_q, aw_wait_q, w_wait_q;
	ucb_pkg::addr_t                araddr_q, awaddr_q;
	ucb_pkg::axi_id_t              arid_q, awid_q;
	ucb_pkg::word_t                wdata_q;

	initial begin
		error_count = 0;
		check_count = 0;
	end

	// Unwritten memory reads back as its address under a fixed pattern
	function automatic ucb_pkg::word_t init_word(input ucb_pkg::addr_t a);
		return a ^ 32'hC0DE_5A5A;
	endfunction

	function automatic ucb_pkg::word_t expected_word(input ucb_pkg::addr_t a);
		return ref_mem.exists(a) ? ref_mem[a] : init_word(a);
	endfunction

	// Each port owns the region whose top byte is 0x10 plus its index
	function automatic int port_of(input ucb_pkg::addr_t a);
		return int'(a[31:24]) - 16;
	endfunction

	function automatic string test_name(input logic [2:0] ph);
		case (ph)
			3'd0: return "reset";
			3'd1: return "single_load";
			3'd2: return "store_load";
			3'd3: return "random";
			3'd4: return "backpressure";
			default: return "unknown";
		endcase
	endfunction

	task automatic check_value(input string what, input logic [31:0] exp,
		input logic [31:0] act);
		check_count++;
		if (exp !== act) begin
			error_count++;
			$display("Error %s %s: expected %h, actual %h", test_name(phase), what, exp, act);
		end
	endtask

	task automatic report_fail(input string msg);
		error_count++;
		$display("Error %s: %s", test_name(phase), msg);
	endtask

	// Everything is sampled mid-cycle, away from both drive points
	always @(negedge clk) begin
		if (rst) begin
			pending   = '0;
			stall_q   = '0;
			ar_wait_q = 1'b0;
			aw_wait_q = 1'b0;
			w_wait_q  = 1'b0;
		end else begin
			if (phase == 3'd0) begin
				check_value("stall after reset", 32'd0, 32'(cpu_stall));
				check_value("valids after reset", 32'd0, {29'd0, arvalid, awvalid, wvalid});
			end
			for (int p = 0; p < ucb_pkg::NUM_PORTS; p++) begin
				// Stall just fell, so rddata holds the result
				if (stall_q[p] && !cpu_stall[p] && pending[p]) begin
					check_value($sformatf("port %0d rddata", p), pend_exp[p], cpu_rddata[p]);
					pending[p] = 1'b0;
				end
				if (!cpu_stall[p] && (cpu_read[p] || cpu_write[p])) begin
					if (cpu_read[p]) begin
						pend_exp[p] = expected_word(cpu_address[p]);
					end else begin
						ref_mem[cpu_address[p]] = cpu_wrdata[p];
						pend_exp[p] = cpu_wrdata[p];
					end
					pending[p] = 1'b1;
				end
			end
			stall_q = cpu_stall;

			if (arvalid && arready) begin
				check_value("arid", 32'(port_of(araddr)), 32'(arid));
				check_value("ar len/size/burst", {19'd0, 8'd0, 3'd2, 2'b01},
					{19'd0, arlen, arsize, arburst});
			end
			if (awvalid && awready) begin
				check_value("awid", 32'(port_of(awaddr)), 32'(awid));
				check_value("aw len/size/burst", {19'd0, 8'd0, 3'd2, 2'b01},
					{19'd0, awlen, awsize, awburst});
			end
			if (wvalid && wready) begin
				check_value("wstrb/wlast", 32'h1F, {27'd0, wstrb, wlast});
			end
			check_value("rready/bready", 32'd3, {30'd0, rready, bready});

			if (ar_wait_q && !(arvalid && araddr == araddr_q && arid == arid_q)) begin
				report_fail("AR valid dropped or its payload changed before the handshake");
			end
			if (aw_wait_q && !(awvalid && awaddr == awaddr_q && awid == awid_q)) begin
				report_fail("AW valid dropped or its payload changed before the handshake");
			end
			if (w_wait_q && !(wvalid && wdata == wdata_q)) begin
				report_fail("W valid dropped or its data changed before the handshake");
			end
			ar_wait_q = arvalid && !arready;
			aw_wait_q = awvalid && !awready;
			w_wait_q  = wvalid && !wready;
			araddr_q  = araddr;
			arid_q    = arid;
			awaddr_q  = awaddr;
			awid_q    = awid;
			wdata_q   = wdata;
		end
	end

endmodule

`default_nettype wire

//--- tests/tb_uncached_bridge.sv
`default_nettype none

module tb_uncached_bridge;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int STALL_LIMIT = 200;
	localparam int RUN_LIMIT   = 20000;
	localparam int RUN_COUNT   = 50;

	logic                                    clk;
	logic                                    rst;
	logic [ucb_pkg::NUM_PORTS-1:0]           cpu_read, cpu_write, cpu_stall;
	ucb_pkg::addr_t [ucb_pkg::NUM_PORTS-1:0] cpu_address;
	ucb_pkg::word_t [ucb_pkg::NUM_PORTS-1:0] cpu_wrdata, cpu_rddata;
	ucb_pkg::axi_id_t                        arid, awid, rid, bid;
	ucb_pkg::addr_t                          araddr, awaddr;
	ucb_pkg::word_t                          wdata, rdata;
	logic [7:0]                              arlen, awlen;
	logic [2:0]                              arsize, awsize;
	logic [1:0]                              arburst, awburst, rresp, bresp;
	logic                                    arvalid, arready, awvalid, awready;
	logic                                    wvalid, wready, wlast;
	logic [3:0]                              wstrb;
	logic                                    rvalid, rready, rlast, bvalid, bready;

	logic [2:0]  phase;
	logic        backpressure;
	logic        hung;
	int          timeouts;
	int          ports_done;
	int          error_count, check_count;
	logic [31:0] rng_state = 32'd79697;

	// AXI slave memory state
	ucb_pkg::word_t   mem [ucb_pkg::addr_t];
	logic             r_busy;
	logic [1:0]       r_wait, b_wait, w_stage;
	ucb_pkg::axi_id_t r_id, w_id;
	ucb_pkg::addr_t   r_addr, w_addr;
	logic [31:0]      roll;

	uncached_bridge_top dut_i (.*);

	ucb_checker checker_i (.*);

	always #5 clk = ~clk;

	function automatic logic [31:0] next_random();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	function automatic ucb_pkg::word_t init_word(input ucb_pkg::addr_t a);
		return a ^ 32'hC0DE_5A5A;
	endfunction

	function automatic ucb_pkg::word_t read_mem(input ucb_pkg::addr_t a);
		return mem.exists(a) ? mem[a] : init_word(a);
	endfunction

	function automatic ucb_pkg::addr_t region_addr(input int p, input logic [5:0] off);
		return {8'h10 + 8'(p), 16'h0000, off, 2'b00};
	endfunction

	// Slave samples on the edge and drives 1 ns later
	always begin
		@(posedge clk);
		roll = next_random();
		if (rst) begin
			r_busy  = 1'b0;
			r_wait  = 2'd0;
			w_stage = 2'd0;
			b_wait  = 2'd0;
			r_id    = '0;
			w_id    = '0;
			r_addr  = '0;
			w_addr  = '0;
		end else begin
			if (rvalid && rready) begin
				r_busy = 1'b0;
			end else if (r_busy && r_wait != 2'd0) begin
				r_wait = r_wait - 2'd1;
			end
			if (arvalid && arready) begin
				r_busy = 1'b1;
				r_id   = arid;
				r_addr = araddr;
				r_wait = roll[3:2];
			end
			if (bvalid && bready) begin
				w_stage = 2'd0;
			end else if (w_stage == 2'd2 && b_wait != 2'd0) begin
				b_wait = b_wait - 2'd1;
			end
			if (awvalid && awready) begin
				w_stage = 2'd1;
				w_id    = awid;
				w_addr  = awaddr;
			end
			if (wvalid && wready) begin
				mem[w_addr] = wdata;
				w_stage     = 2'd2;
				b_wait      = roll[5:4];
			end
		end
		#1;
		roll    = next_random();
		arready = !rst && !r_busy && (!backpressure || roll[0]);
		awready = !rst && (w_stage == 2'd0) && (!backpressure || roll[1]);
		wready  = !rst && (w_stage == 2'd1) && (!backpressure || roll[2]);
		rvalid  = r_busy && (r_wait == 2'd0);
		rid     = r_id;
		rdata   = read_mem(r_addr);
		rlast   = 1'b1;
		bvalid  = (w_stage == 2'd2) && (b_wait == 2'd0);
		bid     = w_id;
	end

	task automatic do_access(input int p, input logic is_store, input ucb_pkg::addr_t a,
		input ucb_pkg::word_t d);
		int waited;
		@(posedge clk);
		#1;
		cpu_address[p] = a;
		cpu_wrdata[p]  = d;
		cpu_read[p]    = !is_store;
		cpu_write[p]   = is_store;
		@(posedge clk);
		#1;
		cpu_read[p]  = 1'b0;
		cpu_write[p] = 1'b0;
		waited = 0;
		do begin
			@(negedge clk);
			waited++;
		end while (cpu_stall[p] && waited < STALL_LIMIT);
		if (cpu_stall[p]) begin
			$display("Port %0d stayed stalled for %0d cycles and never finished", p, STALL_LIMIT);
			timeouts++;
			hung = 1'b1;
		end
	endtask

	task automatic run_random(input int p, input int count);
		logic [31:0] r;
		for (int i = 0; i < count; i++) begin
			if (!hung) begin
				r = next_random();
				do_access(p, r[0], region_addr(p, r[13:8]), next_random());
			end
		end
		ports_done++;
	endtask

	task automatic run_ports();
		int guard;
		ports_done = 0;
		for (int p = 0; p < ucb_pkg::NUM_PORTS; p++) begin
			fork
				automatic int port = p;
				run_random(port, RUN_COUNT);
			join_none
		end
		guard = 0;
		while (ports_done < ucb_pkg::NUM_PORTS && guard < RUN_LIMIT) begin
			@(posedge clk);
			guard++;
		end
		if (ports_done < ucb_pkg::NUM_PORTS) begin
			$display("Concurrent traffic did not complete within %0d cycles", RUN_LIMIT);
			timeouts++;
			hung = 1'b1;
		end
	endtask

	task automatic set_phase(input logic [2:0] ph);
		@(posedge clk);
		#1;
		phase = ph;
	endtask

	initial begin
		clk          = 1'b0;
		rst          = 1'b1;
		cpu_read     = '0;
		cpu_write    = '0;
		cpu_address  = '0;
		cpu_wrdata   = '0;
		arready      = 1'b0;
		awready      = 1'b0;
		wready       = 1'b0;
		rid          = '0;
		rdata        = '0;
		rresp        = 2'b00;
		rlast        = 1'b0;
		rvalid       = 1'b0;
		bid          = '0;
		bresp        = 2'b00;
		bvalid       = 1'b0;
		phase        = 3'd0;
		backpressure = 1'b0;
		hung         = 1'b0;
		timeouts     = 0;
		repeat (5) @(posedge clk);
		#1;
		rst = 1'b0;
		repeat (3) @(posedge clk);

		set_phase(3'd1);
		do_access(0, 1'b0, region_addr(0, 6'h05), '0);

		set_phase(3'd2);
		do_access(1, 1'b1, region_addr(1, 6'h0A), next_random());
		do_access(1, 1'b0, region_addr(1, 6'h0A), '0);

		set_phase(3'd3);
		run_ports();

		set_phase(3'd4);
		backpressure = 1'b1;
		run_ports();

		repeat (4) @(posedge clk);
		$display("Summary: %0d checks, %0d errors, %0d timeouts",
			check_count, error_count, timeouts);
		if (error_count == 0 && timeouts == 0 && check_count > 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- uncached_bridge.f
common/ucb_pkg.sv
design/dbus_pass.sv
design/axi_id_arbiter.sv
design/uncached_bridge_top.sv
tests/ucb_checker.sv
tests/tb_uncached_bridge.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the uncached bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	-f uncached_bridge.f \
	--top-module tb_uncached_bridge \
	> "$BUILD_LOG" 2>&1
build_status=$?
if [ $build_status -ne 0 ]; then
	cat "$BUILD_LOG"
	echo "Verilator build failed with status $build_status"
	exit 1
fi

./obj_dir/Vtb_uncached_bridge > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if grep -qF '*** FAILED ***' "$SIM_LOG"; then
	exit 1
fi

exit 0
